// File: evb_pkg.sv
package evb_pkg;

	// Cache line geometry
	localparam int ADDR_W = 16;    // Line address bits
	localparam int LINE_W = 1024;  // Bits per cache line

	// External port beat width unless the top level overrides it
	localparam int BEAT_W_DEFAULT = 64;

	typedef logic [ADDR_W-1:0] line_addr_t;  // Line-granular address
	typedef logic [LINE_W-1:0] line_t;       // One whole line

	// Beats needed to move one line
	function automatic int beat_count(input int beat_w);
		return LINE_W / beat_w;
	endfunction

	// Width of the beat index, never below one bit
	// A single-beat line still gets a constant zero index bit on mem_addr
	function automatic int beat_idx_w(input int beat_w);
		int n;
		n = LINE_W / beat_w;
		if (n > 1)
			return $clog2(n);
		else
			return 1;
	endfunction

	// Victim buffer states
	typedef enum logic [1:0] {
		EMPTY     = 2'd0,  // Nothing held
		DELAY     = 2'd1,  // One cycle for the cache to issue its miss
		FULL      = 2'd2,  // Line held and not yet written back
		WRITEBACK = 2'd3   // Line going out to memory
	} evb_state_e;

endpackage

// File: evb_subsystem.sv
`timescale 1ns/1ps

// Eviction buffer in front of the burst adapter
// Cache on one side, narrow memory port on the other
module evb_subsystem #(
	parameter int BEAT_W = evb_pkg::BEAT_W_DEFAULT
) (
	input  logic                clk,
	input  logic                rst_n,

	// Cache side, level request with a one-cycle resp
	input  logic                ev_read,
	input  logic                ev_write,
	input  evb_pkg::line_addr_t ev_addr,
	input  evb_pkg::line_t      ev_wdata,
	output evb_pkg::line_t      ev_rdata,
	output logic                ev_resp,

	// Memory side, one beat per mem_ready
	output logic                mem_read,
	output logic                mem_write,
	output logic [evb_pkg::ADDR_W+evb_pkg::beat_idx_w(BEAT_W)-1:0] mem_addr,
	output logic [BEAT_W-1:0]   mem_wdata,
	input  logic [BEAT_W-1:0]   mem_rdata,
	input  logic                mem_ready
);

	// Link between the two stages
	line_req_if line_if ();

	// Stage 1: victim buffer
	eviction_buffer eviction_buffer_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.read  (ev_read),
		.write (ev_write),
		.addr  (ev_addr),
		.wdata (ev_wdata),
		.rdata (ev_rdata),
		.resp  (ev_resp),
		.down  (line_if)
	);

	// Stage 2: line to beats
	line_burst_adapter #(
		.BEAT_W (BEAT_W)
	) line_burst_adapter_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.up        (line_if),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

endmodule

// File: eviction_buffer.sv
`timescale 1ns/1ps

// One-entry victim line buffer between the cache and the burst adapter
module eviction_buffer (
	input  logic                clk,
	input  logic                rst_n,

	// Cache side
	input  logic                read,
	input  logic                write,
	input  evb_pkg::line_addr_t addr,
	input  evb_pkg::line_t      wdata,
	output evb_pkg::line_t      rdata,
	output logic                resp,

	// Toward memory
	line_req_if.requester       down
);

	evb_pkg::evb_state_e state;       // Current buffer state
	evb_pkg::evb_state_e next_state;

	evb_pkg::line_addr_t buf_addr;    // Address of the held line
	evb_pkg::line_t      buf_line;    // Held line at full width
	logic                load;        // Capture addr/wdata into the buffer
	logic                addr_match;  // Incoming request targets the held line

	assign addr_match = (buf_addr == addr);

	always_comb
	begin
		// Default is a quiet downstream carrying the cache request fields
		next_state = state;
		load       = 1'b0;
		resp       = 1'b0;
		rdata      = down.rdata;
		down.read  = 1'b0;
		down.write = 1'b0;
		down.addr  = addr;
		down.wdata = wdata;

		case (state)
			evb_pkg::EMPTY:
			begin
				if (write)
				begin
					// Victim taken at once so the cache can fetch its miss
					load       = 1'b1;
					resp       = 1'b1;
					next_state = evb_pkg::DELAY;
				end
				else if (read)
				begin
					down.read = 1'b1;       // Plain miss to memory
					resp      = down.resp;
				end
			end

			evb_pkg::DELAY,
			evb_pkg::FULL:
			begin
				if (read && addr_match)
				begin
					rdata = buf_line;       // Served straight from the buffer
					resp  = 1'b1;
				end
				else if (write && addr_match)
				begin
					// Newer copy replaces the held one
					// so the later writeback carries it
					load = 1'b1;
					resp = 1'b1;
				end
				else if (read || write)
				begin
					down.read  = read;      // Unrelated line passes through
					down.write = write;
					resp       = down.resp;
				end

				if (state == evb_pkg::DELAY)
					next_state = evb_pkg::FULL;   // DELAY is always one cycle
				else if (!read && !write)
					next_state = evb_pkg::WRITEBACK;  // Cache idle so drain now
			end

			evb_pkg::WRITEBACK:
			begin
				// Cache requests wait here with resp low
				down.write = 1'b1;
				down.addr  = buf_addr;
				down.wdata = buf_line;
				if (down.resp)
					next_state = evb_pkg::EMPTY;
			end

			default:
			begin
				next_state = evb_pkg::EMPTY;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= evb_pkg::EMPTY;
		else
			state <= next_state;
	end

	// Line storage
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			buf_addr <= addr;
			buf_line <= wdata;
		end
	end

	// Cache never asks for both at once
	a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
		!(read && write));

	// Memory answers an EMPTY buffer only for a forwarded read
	a_empty_resp: assert property (@(posedge clk) disable iff (!rst_n)
		(down.resp && state == evb_pkg::EMPTY) |-> down.read);

	// A request held off by the writeback stays up with its address
	a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(state == evb_pkg::WRITEBACK && (read || write))
		|=> ((read || write) && $stable(addr)));

endmodule

// File: flist.f
evb_pkg.sv
line_req_if.sv
eviction_buffer.sv
line_burst_adapter.sv
evb_subsystem.sv
tb_mem_model.sv
tb_evb_subsystem.sv

// File: line_burst_adapter.sv
`timescale 1ns/1ps

// Splits one line request into LINE_W/BEAT_W beats on the memory port
module line_burst_adapter #(
	parameter int BEAT_W = evb_pkg::BEAT_W_DEFAULT
) (
	input  logic              clk,
	input  logic              rst_n,

	// Line side
	line_req_if.responder     up,

	// External memory port
	output logic              mem_read,
	output logic              mem_write,
	output logic [evb_pkg::ADDR_W+evb_pkg::beat_idx_w(BEAT_W)-1:0] mem_addr,
	output logic [BEAT_W-1:0] mem_wdata,
	input  logic [BEAT_W-1:0] mem_rdata,
	input  logic              mem_ready
);

	localparam int NBEATS = evb_pkg::beat_count(BEAT_W);
	localparam int IDX_W  = evb_pkg::beat_idx_w(BEAT_W);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NBEATS - 1);

	typedef enum logic [1:0] {
		IDLE = 2'd0,  // First beat may already go out while waiting
		XFER = 2'd1,  // Remaining beats
		DONE = 2'd2   // Resp cycle then one guard cycle
	} adp_state_e;

	adp_state_e       state;
	logic [IDX_W-1:0] beat_idx;   // Next beat to move
	logic             resp_q;     // High for the first DONE cycle only
	evb_pkg::line_t   line_q;     // Read beats gathered here
	logic             req;
	logic             active;     // Allowed to drive the memory port
	logic             beat_done;  // Memory took or gave a beat this cycle
	logic             last_beat;

	assign req       = up.read || up.write;
	assign active    = (state != DONE);
	assign last_beat = (beat_idx == LAST_IDX);

	// Beats start in the request cycle itself
	assign mem_read  = active && up.read;
	assign mem_write = active && up.write;
	assign beat_done = mem_ready && (mem_read || mem_write);

	// Line address above the beat index
	assign mem_addr  = {up.addr, beat_idx};
	assign mem_wdata = up.wdata[beat_idx*BEAT_W +: BEAT_W];

	assign up.rdata  = line_q;
	assign up.resp   = resp_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= IDLE;
			beat_idx <= '0;
			resp_q   <= 1'b0;
		end
		else
		begin
			resp_q <= 1'b0;

			case (state)
				IDLE,
				XFER:
				begin
					if (beat_done && last_beat)
					begin
						state  <= DONE;   // Resp goes out next cycle
						resp_q <= 1'b1;
					end
					else if (req)
						state <= XFER;
				end

				DONE:
				begin
					// Second DONE cycle ignores a request still seen at the resp edge
					if (!resp_q)
						state <= IDLE;
				end

				default:
				begin
					state <= IDLE;
				end
			endcase

			if (beat_done)
				beat_idx <= last_beat ? '0 : beat_idx + 1'b1;
		end
	end

	// Read beats land in their slice of the line
	always_ff @(posedge clk)
	begin
		if (beat_done && mem_read)
			line_q[beat_idx*BEAT_W +: BEAT_W] <= mem_rdata;
	end

	a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read && mem_write));

	// Upstream keeps its request up for the whole burst
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(state == XFER) |-> req);

	// A stalled beat keeps its address while upstream holds addr until resp
	a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		((mem_read || mem_write) && !mem_ready) |=> $stable(mem_addr));

endmodule

// File: line_req_if.sv
`timescale 1ns/1ps

// Line-wide request/response between two pipeline stages
// Request is a level held until resp, resp is a single-cycle pulse
interface line_req_if;

	logic               read;   // Read level
	logic               write;  // Write level, never together with read
	evb_pkg::line_addr_t addr;  // Line address
	evb_pkg::line_t     wdata;  // Line to store
	evb_pkg::line_t     rdata;  // Valid in the resp cycle
	logic               resp;   // Completion pulse

	// Upstream side
	modport requester (
		output read,
		output write,
		output addr,
		output wdata,
		input  rdata,
		input  resp
	);

	// Downstream side
	modport responder (
		input  read,
		input  write,
		input  addr,
		input  wdata,
		output rdata,
		output resp
	);

endinterface

// File: tb_evb_subsystem.sv
`timescale 1ns/1ps

module tb_evb_subsystem;

	localparam int BEAT_W     = evb_pkg::BEAT_W_DEFAULT;
	localparam int NBEATS     = evb_pkg::beat_count(BEAT_W);
	localparam int IDX_W      = evb_pkg::beat_idx_w(BEAT_W);
	localparam int MEM_AW     = evb_pkg::ADDR_W + IDX_W;
	localparam int MAX_STALL  = 3;                              // Longest ready gap
	localparam int N_SET      = 4;                              // Lines in the random mix
	localparam int N_RAND     = 40;                             // Random requests
	localparam int XFER_CYC   = NBEATS * (MAX_STALL + 1) + 4;   // Worst line transfer
	localparam int REQ_LIMIT  = 3 * XFER_CYC;                   // Writeback wait plus own transfer
	localparam int N_XFER     = 16 + 2 * (N_SET + N_RAND) + N_SET + 3;
	localparam int WD_CYCLES  = N_XFER * XFER_CYC + N_RAND * 8 + 200;

	localparam evb_pkg::line_addr_t A0       = 16'h1234;
	localparam evb_pkg::line_addr_t A1       = 16'h0abc;
	localparam evb_pkg::line_addr_t A2       = 16'hfe01;
	localparam evb_pkg::line_addr_t SET_BASE = 16'h0200;

	logic                clk;
	logic                rst_n;
	logic                ev_read;
	logic                ev_write;
	evb_pkg::line_addr_t ev_addr;
	evb_pkg::line_t      ev_wdata;
	evb_pkg::line_t      ev_rdata;
	logic                ev_resp;
	logic                mem_read;
	logic                mem_write;
	logic [MEM_AW-1:0]   mem_addr;
	logic [BEAT_W-1:0]   mem_wdata;
	logic [BEAT_W-1:0]   mem_rdata;
	logic                mem_ready;

	evb_pkg::line_t      golden [evb_pkg::line_addr_t];  // Last line the cache wrote
	evb_pkg::line_t      exp_line;                       // Expected data of the current read
	int                  check_errors;
	int                  assert_errors;

	evb_pkg::evb_state_e buf_state;
	evb_pkg::line_addr_t buf_addr;
	assign buf_state = evb_subsystem_inst.eviction_buffer_inst.state;
	assign buf_addr  = evb_subsystem_inst.eviction_buffer_inst.buf_addr;

	always #4 clk = ~clk;  // 8 ns period

	evb_subsystem #(
		.BEAT_W (BEAT_W)
	) evb_subsystem_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.ev_read   (ev_read),
		.ev_write  (ev_write),
		.ev_addr   (ev_addr),
		.ev_wdata  (ev_wdata),
		.ev_rdata  (ev_rdata),
		.ev_resp   (ev_resp),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

	tb_mem_model #(
		.BEAT_W    (BEAT_W),
		.AW        (MEM_AW),
		.MAX_STALL (MAX_STALL)
	) mem_model_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready)
	);

	// Quiet outputs in reset and on the first edge after it
	a_reset_quiet: assert property (@(posedge clk)
		(!rst_n || $rose(rst_n)) |-> (!ev_resp && !mem_read && !mem_write))
	else
	begin
		assert_errors++;
		$display("Outputs active during or right after reset");
	end

	// Victim taken in the cycle it is offered
	a_empty_write_ack: assert property (@(posedge clk) disable iff (!rst_n)
		(ev_write && buf_state == evb_pkg::EMPTY) |-> ev_resp)
	else
	begin
		assert_errors++;
		$display("Write to the empty buffer not acknowledged at once");
	end

	// Hits on the held line stay off the memory port
	a_hit_local: assert property (@(posedge clk) disable iff (!rst_n)
		((ev_read || ev_write) && ev_addr == buf_addr
			&& (buf_state == evb_pkg::DELAY || buf_state == evb_pkg::FULL))
		|-> (ev_resp && !mem_read && !mem_write))
	else
	begin
		assert_errors++;
		$display("Hit on line %h not served by the buffer", $sampled(ev_addr));
	end

	a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
		(ev_resp && ev_read) |-> (ev_rdata == exp_line))
	else
	begin
		assert_errors++;
		$display("FAIL ev_rdata line %h got %h exp %h", $sampled(ev_addr),
			$sampled(ev_rdata), $sampled(exp_line));
	end

	function automatic evb_pkg::line_t rand_line();
		evb_pkg::line_t l;
		int i;
		for (i = 0; i < evb_pkg::LINE_W / 32; i++)
			l[i*32 +: 32] = $urandom;
		return l;
	endfunction

	// Beats seen on the memory port so far
	function automatic int mem_beats();
		return mem_model_inst.rd_beats + mem_model_inst.wr_log.size();
	endfunction

	// Holds the request until ev_resp, starts and ends 1 ns after an edge
	task automatic run_request(input logic rd, input evb_pkg::line_addr_t a,
		input evb_pkg::line_t d);
		int   waited;
		logic done;
		waited   = 0;
		done     = 1'b0;
		ev_read  = rd;
		ev_write = !rd;
		ev_addr  = a;
		ev_wdata = d;
		if (rd)
			exp_line = golden[a];
		while (!done && waited < REQ_LIMIT)
		begin
			@(negedge clk);
			done = ev_resp;   // Settled mid-cycle
			@(posedge clk);
			#1;
			waited++;
		end
		ev_read  = 1'b0;
		ev_write = 1'b0;
		if (!done)
		begin
			check_errors++;
			$display("Request to line %h got no ev_resp in %0d cycles", a, REQ_LIMIT);
		end
		else if (!rd)
			golden[a] = d;
	endtask

	task automatic read_line(input evb_pkg::line_addr_t a);
		run_request(1'b1, a, '0);
	endtask

	task automatic write_line(input evb_pkg::line_addr_t a, input evb_pkg::line_t d);
		run_request(1'b0, a, d);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// Cache idle until the held line has gone out
	task automatic wait_drained();
		int waited;
		waited = 0;
		while (buf_state != evb_pkg::EMPTY && waited < REQ_LIMIT)
		begin
			idle_cycles(1);
			waited++;
		end
		assert (buf_state == evb_pkg::EMPTY)
		else
		begin
			check_errors++;
			$display("Buffer not drained within %0d cycles", REQ_LIMIT);
		end
	endtask

	// Writeback of line a as ascending beats, then the memory copy is read back
	task automatic check_writeback(input evb_pkg::line_addr_t a);
		int                start;
		int                i;
		logic [MEM_AW-1:0] exp_addr;
		start = mem_model_inst.wr_log.size();
		wait_drained();
		assert (mem_model_inst.wr_log.size() - start == NBEATS)
		else
		begin
			check_errors++;
			$display("Writeback of line %h moved %0d beats instead of %0d", a,
				mem_model_inst.wr_log.size() - start, NBEATS);
		end
		for (i = 0; i < NBEATS && start + i < mem_model_inst.wr_log.size(); i++)
		begin
			exp_addr = {a, IDX_W'(i)};
			assert (mem_model_inst.wr_log[start + i] == exp_addr)
			else
			begin
				check_errors++;
				$display("FAIL mem_addr beat %0d got %h exp %h", i,
					mem_model_inst.wr_log[start + i], exp_addr);
			end
		end
		read_line(a);  // Buffer empty, so this comes from memory
	endtask

	initial
	begin
		int                  i;
		int                  beats;
		evb_pkg::line_addr_t a;
		void'($urandom(32'h19ffbbc9));
		clk           = 1'b0;
		rst_n         = 1'b0;
		ev_read       = 1'b0;
		ev_write      = 1'b0;
		ev_addr       = '0;
		ev_wdata      = '0;
		exp_line      = '0;
		check_errors  = 0;
		assert_errors = 0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		idle_cycles(2);

		// Victim capture, then hits in DELAY and FULL
		beats = mem_beats();
		write_line(A0, rand_line());
		read_line(A0);                 // Cycle after the write resp
		write_line(A0, rand_line());   // Overwrites the held copy
		read_line(A0);
		assert (mem_beats() == beats)
		else
		begin
			check_errors++;
			$display("Buffer hits caused memory beats");
		end
		check_writeback(A0);

		// Misses go around a full buffer
		write_line(A1, rand_line());
		read_line(A0);
		write_line(A2, rand_line());
		read_line(A2);
		check_writeback(A1);

		// Random traffic on a small set, idle gaps let writebacks start
		for (i = 0; i < N_SET; i++)
			write_line(SET_BASE + 16'(i), rand_line());
		for (i = 0; i < N_RAND; i++)
		begin
			a = SET_BASE + 16'($urandom_range(N_SET - 1, 0));
			if ($urandom_range(1, 0) == 1)
				read_line(a);
			else
				write_line(a, rand_line());
			if ($urandom_range(3, 0) == 0)
				idle_cycles($urandom_range(6, 1));
		end

		// Every line back from memory
		wait_drained();
		foreach (golden[k])
			read_line(k);
		idle_cycles(2);

		$display("Check errors %0d, assertion errors %0d", check_errors, assert_errors);
		if (check_errors == 0 && assert_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Run length bound from the worst-case transfer count
	initial
	begin
		#(WD_CYCLES * 8);
		$display("Watchdog expired after %0d cycles", WD_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/1ps

// Beat-wide memory on the external port
// Ready comes with random gaps, every write beat is logged in order
module tb_mem_model #(
	parameter int BEAT_W    = 64,
	parameter int AW        = 20,
	parameter int MAX_STALL = 3
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_read,
	input  logic              mem_write,
	input  logic [AW-1:0]     mem_addr,
	input  logic [BEAT_W-1:0] mem_wdata,
	output logic [BEAT_W-1:0] mem_rdata,
	output logic              mem_ready
);

	logic [BEAT_W-1:0] mem [logic [AW-1:0]];  // Sparse beat storage
	logic [AW-1:0]     wr_log [$];            // Beat address of each write, oldest first
	int                rd_beats;              // Read beats served so far
	int                wr_count;              // Bumps on each write so reads see it
	int                gap;                   // Low cycles left before the next ready

	// Unwritten beats read as a pattern of the whole address
	function automatic logic [BEAT_W-1:0] fill_word(input logic [AW-1:0] a);
		logic [BEAT_W-1:0] w;
		int i;
		for (i = 0; i < BEAT_W / 32; i++)
			w[i*32 +: 32] = (32'(a) * 32'h9e3779b1) ^ (32'h5a5a0000 + i);
		return w;
	endfunction

	initial
	begin
		mem_ready = 1'b0;
		rd_beats  = 0;
		wr_count  = 0;
		gap       = 0;
	end

	// Read data follows the address within the same cycle
	always @(mem_addr or wr_count)
	begin
		if ($isunknown(mem_addr))
			mem_rdata = '0;               // Address not yet out of reset
		else if (mem.exists(mem_addr))
			mem_rdata = mem[mem_addr];
		else
			mem_rdata = fill_word(mem_addr);
	end

	// Ready moves just after the edge, like the cache-side inputs
	always @(posedge clk)
	begin
		#1;
		if (!rst_n)
			mem_ready = 1'b0;
		else if (gap == 0)
		begin
			mem_ready = 1'b1;
			gap       = $urandom_range(MAX_STALL, 0);  // Next stall length
		end
		else
		begin
			mem_ready = 1'b0;
			gap--;
		end
	end

	// A beat completes at the edge where ready is high
	always @(posedge clk)
	begin
		if (rst_n && mem_ready && mem_write)
		begin
			mem[mem_addr] = mem_wdata;
			wr_log.push_back(mem_addr);
			wr_count++;
		end
		if (rst_n && mem_ready && mem_read)
			rd_beats++;
	end

endmodule
